/* src/rxq_pkg.sv */
// Receive read queue shared types
package rxq_pkg;

  // Width of one queue word
  localparam int unsigned DataWidth = 32;

  // Width of each software threshold field
  localparam int unsigned ThldWidth = 3;

  // Producer write, accepted whenever valid is high
  typedef struct packed {
    logic                 valid;
    logic [DataWidth-1:0] data;
  } rxq_wr_t;

  // Software-set trigger thresholds
  typedef struct packed {
    logic [ThldWidth-1:0] start_thld;
    logic [ThldWidth-1:0] ready_thld;
  } rxq_thld_cfg_t;

  // Queue status flags, depth travels on its own port
  typedef struct packed {
    logic empty;
    logic full;
    logic start_trig;
    logic ready_trig;
  } rxq_status_t;

  // Control FSM states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    FETCH = 2'd1,
    CLEAR = 2'd2
  } rxq_state_e;

endpackage

/* src/rxq_fifo.sv */
// Receive queue FIFO storage
module rxq_fifo import rxq_pkg::*; #(
  parameter int unsigned Depth = 8,
  localparam int unsigned DepthWidth = $clog2(Depth + 1),
  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  rxq_wr_t               wr_i,
  input  logic                  pop_i,
  input  logic                  clr_i,
  output logic [DataWidth-1:0]  rdata_o,
  output logic [DepthWidth-1:0] depth_o,
  output logic                  empty_o,
  output logic                  full_o
);

  logic [DataWidth-1:0]  mem_q [Depth];
  logic [PtrWidth-1:0]   wptr_q;
  logic [PtrWidth-1:0]   rptr_q;
  logic [PtrWidth-1:0]   wr_idx;
  logic [DepthWidth-1:0] cnt_q;
  logic                  push;

  // Pointer advance with wrap for any depth
  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push = wr_i.valid;

  // A write during clear lands in the first slot
  assign wr_idx = clr_i ? '0 : wptr_q;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_idx] <= wr_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        wptr_q <= ptr_inc(wr_idx);
      end else if (clr_i) begin
        wptr_q <= '0;
      end

      if (clr_i) begin
        rptr_q <= '0;
        cnt_q  <= DepthWidth'(push);
      end else begin
        if (pop_i) begin
          rptr_q <= ptr_inc(rptr_q);
        end
        cnt_q <= cnt_q + DepthWidth'(push) - DepthWidth'(pop_i);
      end
    end
  end

  assign rdata_o = mem_q[rptr_q];
  assign depth_o = cnt_q;
  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == DepthWidth'(Depth));

  // Producer credits must keep the queue from overflowing
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(push && full_o));

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(pop_i && empty_o));

endmodule

/* src/rxq_credit_counter.sv */
// Producer credit counter
module rxq_credit_counter #(
  parameter int unsigned Depth = 8,
  localparam int unsigned DepthWidth = $clog2(Depth + 1)
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  pop_i,
  input  logic                  drop_i,
  input  logic [DepthWidth-1:0] drop_cnt_i,
  output logic                  credit_o
);

  logic [DepthWidth-1:0] cnt_q;
  logic [DepthWidth-1:0] cnt_d;
  logic                  issue;
  logic                  credit_q;

  // One credit leaves per cycle while any are pending
  assign issue = (cnt_q != '0);

  always_comb begin
    cnt_d = cnt_q - DepthWidth'(issue) + DepthWidth'(pop_i);
    // Entries lost in a clear come back as credits
    if (drop_i) begin
      cnt_d = cnt_d + drop_cnt_i;
    end
  end

  // Every entry starts out as a pending credit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= DepthWidth'(Depth);
      credit_q <= 1'b0;
    end else begin
      cnt_q    <= cnt_d;
      credit_q <= issue;
    end
  end

  assign credit_o = credit_q;

  // Pending plus issued credits plus occupancy stay at Depth
  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= DepthWidth'(Depth));

endmodule

/* src/rxq_thld.sv */
// Queue threshold triggers
module rxq_thld import rxq_pkg::*; #(
  parameter int unsigned Depth = 8,
  parameter bit ThldIsPow = 1'b1,
  parameter bit LimitReadyThld = 1'b0,
  localparam int unsigned DepthWidth = $clog2(Depth + 1)
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  rxq_thld_cfg_t         thld_cfg_i,
  input  logic [DepthWidth-1:0] depth_i,
  output logic                  start_trig_o,
  output logic                  ready_trig_o,
  output logic [ThldWidth-1:0]  ready_thld_o
);

  // Wide enough for 2^(2^ThldWidth)
  localparam int unsigned EffWidth = (1 << ThldWidth) + 1;
  localparam logic [ThldWidth-1:0] ClampCount = ThldWidth'(Depth - 1);
  localparam logic [ThldWidth-1:0] ClampPow = ThldWidth'($clog2(Depth) - 1);

  logic [ThldWidth-1:0]  ready_thld_q;
  logic [ThldWidth-1:0]  ready_thld_d;
  logic [DepthWidth-1:0] free_entries;

  // Entry count a threshold field stands for
  function automatic logic [EffWidth-1:0] eff_thld(input logic [ThldWidth-1:0] v);
    if (ThldIsPow) begin
      return EffWidth'(1) << (int'(v) + 1);
    end
    return EffWidth'(v);
  endfunction

  // Clamp so the ready level stays within the queue
  always_comb begin
    ready_thld_d = thld_cfg_i.ready_thld;
    if (LimitReadyThld && (32'(eff_thld(thld_cfg_i.ready_thld)) >= Depth)) begin
      ready_thld_d = ThldIsPow ? ClampPow : ClampCount;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_thld_q <= '0;
    end else begin
      ready_thld_q <= ready_thld_d;
    end
  end

  assign free_entries = DepthWidth'(Depth) - depth_i;

  // A zero field disables its trigger
  assign start_trig_o = (thld_cfg_i.start_thld != '0) &&
                        (32'(free_entries) >= 32'(eff_thld(thld_cfg_i.start_thld)));
  assign ready_trig_o = (ready_thld_q != '0) &&
                        (32'(depth_i) >= 32'(eff_thld(ready_thld_q)));

  assign ready_thld_o = ready_thld_q;

endmodule

/* src/rxq_ctrl_fsm.sv */
// Software read and reset control
module rxq_ctrl_fsm import rxq_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic                 reg_rst_i,
  input  logic                 empty_i,
  input  logic [DataWidth-1:0] rdata_i,
  output logic                 pop_o,
  output logic                 clr_o,
  output logic                 ack_o,
  output logic [DataWidth-1:0] data_o,
  output logic                 reg_rst_we_o
);

  rxq_state_e           state_q;
  rxq_state_e           state_d;
  logic                 rst_req;
  logic                 ack_q;
  logic                 rst_we_q;
  logic [DataWidth-1:0] data_q;

  // Ignore the reset bit while its write-back is in flight
  assign rst_req = reg_rst_i && !rst_we_q;

  always_comb begin
    state_d = state_q;
    pop_o   = 1'b0;
    clr_o   = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (rst_req) begin
          state_d = CLEAR;
        end else if (req_i) begin
          state_d = FETCH;
        end
      end
      FETCH: begin
        // Wait here until a word arrives
        if (rst_req) begin
          state_d = CLEAR;
        end else if (!empty_i) begin
          pop_o   = 1'b1;
          state_d = IDLE;
        end
      end
      CLEAR: begin
        clr_o   = 1'b1;
        state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      ack_q    <= 1'b0;
      data_q   <= '0;
      rst_we_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      ack_q    <= pop_o;
      data_q   <= pop_o ? rdata_i : '0;
      rst_we_q <= clr_o;
    end
  end

  assign ack_o        = ack_q;
  assign data_o       = data_q;
  assign reg_rst_we_o = rst_we_q;

  // Software read requests are single-cycle pulses
  a_req_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |=> !req_i);

endmodule

/* src/rx_read_queue.sv */
// Receive read queue top level
module rx_read_queue import rxq_pkg::*; #(
  parameter int unsigned Depth = 8,
  parameter bit ThldIsPow = 1'b1,
  parameter bit LimitReadyThld = 1'b0,
  localparam int unsigned DepthWidth = $clog2(Depth + 1)
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  rxq_wr_t               wr_i,
  output logic                  credit_o,
  input  logic                  req_i,
  output logic                  ack_o,
  output logic [DataWidth-1:0]  data_o,
  input  rxq_thld_cfg_t         thld_cfg_i,
  output logic [ThldWidth-1:0]  ready_thld_o,
  output rxq_status_t           status_o,
  output logic [DepthWidth-1:0] depth_o,
  input  logic                  reg_rst_i,
  output logic                  reg_rst_we_o
);

  logic                  fifo_pop;
  logic                  fifo_clr;
  logic [DataWidth-1:0]  fifo_rdata;
  logic [DepthWidth-1:0] fifo_depth;
  logic                  fifo_empty;
  logic                  fifo_full;
  logic                  start_trig;
  logic                  ready_trig;

  rxq_fifo #(.Depth(Depth)) i_fifo (
    .clk_i, .rst_ni, .wr_i,
    .pop_i(fifo_pop), .clr_i(fifo_clr), .rdata_o(fifo_rdata),
    .depth_o(fifo_depth), .empty_o(fifo_empty), .full_o(fifo_full)
  );

  // Cleared entries are returned to the producer as credits
  rxq_credit_counter #(.Depth(Depth)) i_credit (
    .clk_i, .rst_ni, .pop_i(fifo_pop), .drop_i(fifo_clr),
    .drop_cnt_i(fifo_depth), .credit_o
  );

  rxq_thld #(.Depth(Depth), .ThldIsPow(ThldIsPow), .LimitReadyThld(LimitReadyThld)) i_thld (
    .clk_i, .rst_ni, .thld_cfg_i, .depth_i(fifo_depth),
    .start_trig_o(start_trig), .ready_trig_o(ready_trig), .ready_thld_o
  );

  rxq_ctrl_fsm i_ctrl (
    .clk_i, .rst_ni, .req_i, .reg_rst_i, .empty_i(fifo_empty), .rdata_i(fifo_rdata),
    .pop_o(fifo_pop), .clr_o(fifo_clr), .ack_o, .data_o, .reg_rst_we_o
  );

  assign status_o = '{empty: fifo_empty, full: fifo_full,
                      start_trig: start_trig, ready_trig: ready_trig};
  assign depth_o  = fifo_depth;

endmodule

/* verif/tb_rx_read_queue.sv */
// Receive read queue testbench
module tb_rx_read_queue import rxq_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned Depth = 8;
  localparam int unsigned DepthWidth = $clog2(Depth + 1);
  localparam bit ThldIsPow = 1'b1;
  localparam bit LimitReadyThld = 1'b1;
  localparam int Timeout = 200;

  // Expected trigger outputs for one fill level
  typedef struct packed {
    logic                 start_trig;
    logic                 ready_trig;
    logic [ThldWidth-1:0] ready_thld;
  } exp_t;

  logic                  clk_i;
  logic                  rst_ni;
  rxq_wr_t               wr;
  logic                  credit;
  logic                  req;
  logic                  ack;
  logic [DataWidth-1:0]  rdata;
  rxq_thld_cfg_t         thld_cfg;
  logic [ThldWidth-1:0]  ready_thld;
  rxq_status_t           status;
  logic [DepthWidth-1:0] depth;
  logic                  reg_rst;
  logic                  reg_rst_we;

  logic [DataWidth-1:0] model_q[$];
  int errors = 0;
  int checks = 0;
  int prod_credits = 0;
  int credit_total = 0;
  int ack_cnt = 0;
  int rst_we_cnt = 0;
  bit prod_en = 1'b0;

  rx_read_queue #(.Depth(Depth), .ThldIsPow(ThldIsPow), .LimitReadyThld(LimitReadyThld)) i_dut (
    .clk_i, .rst_ni, .wr_i(wr), .credit_o(credit), .req_i(req), .ack_o(ack),
    .data_o(rdata), .thld_cfg_i(thld_cfg), .ready_thld_o(ready_thld), .status_o(status),
    .depth_o(depth), .reg_rst_i(reg_rst), .reg_rst_we_o(reg_rst_we)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s at %0t: got 0x%0h, expected 0x%0h", name, $time, got, exp);
    end
  endtask

  // Entry count a threshold field stands for
  function automatic int thld_level(input logic [ThldWidth-1:0] v);
    return ThldIsPow ? (1 << (int'(v) + 1)) : int'(v);
  endfunction

  function automatic exp_t ref_thld(input int level, input rxq_thld_cfg_t cfg);
    exp_t r;
    int free;
    free = int'(Depth) - level;
    r.ready_thld = cfg.ready_thld;
    if (LimitReadyThld && thld_level(cfg.ready_thld) >= int'(Depth)) begin
      r.ready_thld = ThldIsPow ? ThldWidth'($clog2(Depth) - 1) : ThldWidth'(Depth - 1);
    end
    r.start_trig = (cfg.start_thld != '0) && (free >= thld_level(cfg.start_thld));
    r.ready_trig = (r.ready_thld != '0) && (level >= thld_level(r.ready_thld));
    return r;
  endfunction

  // Producer spends credits on random words
  always @(negedge clk_i) begin
    if (rst_ni && credit) begin
      prod_credits++;
      credit_total++;
    end
    if (prod_en && prod_credits > 0 && ($urandom % 2 == 0)) begin
      wr.valid = 1'b1;
      wr.data  = DataWidth'($urandom);
      prod_credits--;
    end else begin
      wr = '0;
    end
  end

  // Model update and output checks once the edge has settled
  always @(posedge clk_i) begin
    exp_t e;
    logic [DataWidth-1:0] head;
    #1;
    if (rst_ni) begin
      if (ack) begin
        ack_cnt++;
        if (model_q.size() == 0) begin
          errors++;
          $display("Acknowledge at %0t while no word was stored", $time);
        end else begin
          head = model_q.pop_front();
          check("data_o", 64'(rdata), 64'(head));
        end
      end else begin
        check("data_o", 64'(rdata), 64'(0));
      end
      if (reg_rst_we) begin
        rst_we_cnt++;
        model_q.delete();
      end
      if (wr.valid) model_q.push_back(wr.data);
      e = ref_thld(model_q.size(), thld_cfg);
      check("depth_o", 64'(depth), 64'(model_q.size()));
      check("status_o.empty", 64'(status.empty), 64'(model_q.size() == 0));
      check("status_o.full", 64'(status.full), 64'(model_q.size() == int'(Depth)));
      check("status_o.start_trig", 64'(status.start_trig), 64'(e.start_trig));
      check("status_o.ready_trig", 64'(status.ready_trig), 64'(e.ready_trig));
      check("ready_thld_o", 64'(ready_thld), 64'(e.ready_thld));
      if (int'(depth) > int'(Depth)) begin
        errors++;
        $display("Queue depth %0d went past its size at %0t", depth, $time);
      end
      if (prod_credits + model_q.size() > int'(Depth)) begin
        errors++;
        $display("Producer holds more credits than free entries at %0t", $time);
      end
    end
  end

  task automatic wait_depth(input int lo, input int hi);
    for (int i = 0; i < Timeout && (int'(depth) < lo || int'(depth) > hi); i++) @(negedge clk_i);
    if (int'(depth) < lo || int'(depth) > hi) begin
      errors++;
      $display("Timeout waiting for queue depth between %0d and %0d", lo, hi);
    end
  endtask

  task automatic wait_ack(input int prev);
    for (int i = 0; i < Timeout && ack_cnt == prev; i++) @(negedge clk_i);
    if (ack_cnt == prev) begin
      errors++;
      $display("Timeout waiting for a read acknowledge");
    end
  endtask

  task automatic read_word();
    int prev;
    prev = ack_cnt;
    req = 1'b1;
    @(negedge clk_i);
    req = 1'b0;
    wait_ack(prev);
  endtask

  task automatic random_cfg();
    thld_cfg.start_thld = ThldWidth'($urandom);
    thld_cfg.ready_thld = ThldWidth'($urandom);
    @(negedge clk_i);
  endtask

  initial begin
    int prev;
    void'($urandom(32'h2118_e899));
    rst_ni   = 1'b0;
    wr       = '0;
    req      = 1'b0;
    reg_rst  = 1'b0;
    thld_cfg = '{start_thld: 3'd1, ready_thld: 3'd1};
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;

    // Initial fill uses exactly the reset credits
    prod_en = 1'b1;
    wait_depth(Depth, Depth);
    prod_en = 1'b0;
    @(negedge clk_i);
    check("credit_total", 64'(credit_total), 64'(Depth));

    // Drain and refill under random thresholds
    for (int r = 0; r < 4; r++) begin
      prod_en = 1'b1;
      wait_depth(Depth, Depth);
      prod_en = (r >= 2);
      for (int k = 0; k < int'(Depth); k++) begin
        random_cfg();
        read_word();
      end
    end
    prod_en = 1'b0;
    // Let a write driven on the same edge land before depth is read
    @(negedge clk_i);
    for (int k = 0; k < 2 * int'(Depth) && depth != '0; k++) read_word();
    wait_depth(0, 0);

    // Oversized ready threshold
    thld_cfg.ready_thld = '1;
    @(negedge clk_i);
    check("ready_thld_o", 64'(ready_thld), 64'($clog2(Depth) - 1));

    // Read request on an empty queue
    prev = ack_cnt;
    req = 1'b1;
    @(negedge clk_i);
    req = 1'b0;
    for (int i = 0; i < 10; i++) begin
      @(negedge clk_i);
      if (ack_cnt != prev) begin
        errors++;
        $display("Read on an empty queue was acknowledged before any write");
      end
    end
    prod_en = 1'b1;
    wait_ack(prev);

    // Software reset with words stored
    wait_depth(3, Depth);
    prod_en = 1'b0;
    repeat (2) @(negedge clk_i);
    prev = rst_we_cnt;
    reg_rst = 1'b1;
    for (int i = 0; i < Timeout && rst_we_cnt == prev; i++) @(negedge clk_i);
    reg_rst = 1'b0;
    repeat (4) @(negedge clk_i);
    check("reg_rst_we_o pulses", 64'(rst_we_cnt - prev), 64'(1));
    check("depth_o", 64'(depth), 64'(0));
    for (int i = 0; i < Timeout && prod_credits != int'(Depth); i++) @(negedge clk_i);
    check("producer credits", 64'(prod_credits), 64'(Depth));

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
src/rxq_pkg.sv
src/rxq_fifo.sv
src/rxq_credit_counter.sv
src/rxq_thld.sv
src/rxq_ctrl_fsm.sv
src/rx_read_queue.sv
verif/tb_rx_read_queue.sv

/* run.sh */
#!/bin/sh
# Build and run the receive read queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_rx_read_queue -f tb.f -Mdir obj_dir \
  || { echo "Build failed"; exit 1; }
out=$(./obj_dir/Vtb_rx_read_queue)
echo "$out"
echo "$out" | grep -qx "STATUS: PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
